/* design/rst_consts.svh */
//--------------------
// Shared constants of the reset manager, one clock domain only
// Register addresses are 2 bits wide, data is RST_DATA_W bits
//--------------------
`ifndef RST_CONSTS_SVH
`define RST_CONSTS_SVH

// Downstream reset domains, released in index order
`define RST_NUM_DOMAINS 3

// Synchronizer depth for every reset input
`define RST_SYNC_STAGES 2

// Release stretch per input, in clock cycles
`define RST_POR_STRETCH 4
`define RST_EXT_STRETCH 8

// Cycles all domains stay in reset once a request has ended
`define RST_SOFT_HOLD 16

// Release gap field width and its power-on value
`define RST_GAP_W 8
`define RST_GAP_DEFAULT 4

// Register port
`define RST_ADDR_W 2
`define RST_DATA_W 16
`define RST_ADDR_CTRL 2'd0
`define RST_ADDR_CFG 2'd1
`define RST_ADDR_CAUSE 2'd2
`define RST_ADDR_STATUS 2'd3

`endif

/* design/rst_pkg.sv */
//--------------------
// Types shared by the reset manager blocks
//--------------------
`default_nettype none

`include "rst_consts.svh"

package rst_pkg;

    // Release configuration
    // Hold sits above gap so the struct matches the CFG register layout
    typedef struct packed {
        logic [`RST_NUM_DOMAINS-1:0] hold;
        logic [`RST_GAP_W-1:0]       gap;
    } rst_cfg_t;

    // Sticky reset causes, por in bit 0
    typedef struct packed {
        logic wdt;
        logic sw;
        logic ext;
        logic por;
    } rst_cause_t;

    // One register access per cycle, we and re never together
    typedef struct packed {
        logic                   we;
        logic                   re;
        logic [`RST_ADDR_W-1:0] addr;
        logic [`RST_DATA_W-1:0] wdata;
    } reg_req_t;

endpackage

`default_nettype wire

/* design/reset_stretch_sync.sv */
//--------------------
// Asserts asynchronously, releases RST_SYNC_STAGES + STRETCH_COUNT edges
// after the input rises. STRETCH_COUNT must be at least 1
//--------------------
`default_nettype none

`include "rst_consts.svh"

module reset_stretch_sync #(
    parameter int STRETCH_COUNT = 4
) (
    input  logic clk,
    input  logic async_rst_n,
    output logic sync_rst_n
);

    localparam int STAGES = `RST_SYNC_STAGES;
    localparam int CNT_W  = $clog2(STRETCH_COUNT + 1);

    // Last count before the output is allowed to rise
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STRETCH_COUNT - 1);

    logic [STAGES-1:0] sync_q;
    logic [CNT_W-1:0]  cnt_q;

    // --------------------
    // Synchronizer chain
    // --------------------

    // Constant one shifts in, so only the release edge is synchronized
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], 1'b1};
        end
    end

    // --------------------
    // Release stretch
    // --------------------

    // Counting starts on the first edge that sees the chain output high
    // Output goes high on the edge that finds the counter at its last value
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            cnt_q      <= '0;
            sync_rst_n <= 1'b0;
        end else if (sync_q[STAGES-1] && !sync_rst_n) begin
            if (cnt_q == CNT_LAST) begin
                sync_rst_n <= 1'b1;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* design/reset_sequencer.sv */
//--------------------
// Holds every domain in reset on a request, then releases them in index
// order. cfg is sampled live, so a gap change affects the running sequence
//--------------------
`default_nettype none

`include "rst_consts.svh"

module reset_sequencer (
    input  logic                        clk,
    input  logic                        async_rst_n,
    input  logic                        ext_rst_n,
    input  logic                        sw_rst,
    input  logic                        wdt_bite,
    input  rst_pkg::rst_cfg_t           cfg,
    output logic [`RST_NUM_DOMAINS-1:0] domain_rst_n,
    output logic                        seq_busy
);

    localparam int NDOM   = `RST_NUM_DOMAINS;
    localparam int HOLD_W = $clog2(`RST_SOFT_HOLD);
    localparam int SLOT_W = (NDOM > 1) ? $clog2(NDOM) : 1;

    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`RST_SOFT_HOLD - 1);
    localparam logic [SLOT_W-1:0] SLOT_LAST = SLOT_W'(NDOM - 1);

    typedef enum logic [1:0] {
        ST_HOLD,
        ST_RELEASE,
        ST_IDLE
    } seq_state_t;

    seq_state_t            state_q, state_d;
    logic [HOLD_W-1:0]     hold_cnt_q, hold_cnt_d;
    logic [SLOT_W-1:0]     slot_q, slot_d;
    logic [`RST_GAP_W-1:0] gap_cnt_q, gap_cnt_d;
    // One flag per domain whose release slot has passed
    logic [NDOM-1:0]       opened_q, opened_d;
    logic                  req;

    // Any request source restarts the sequence
    assign req = ~ext_rst_n | sw_rst | wdt_bite;

    // Busy until the last slot has opened
    assign seq_busy = (state_q != ST_IDLE);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_d    = state_q;
        hold_cnt_d = hold_cnt_q;
        slot_d     = slot_q;
        gap_cnt_d  = gap_cnt_q;
        opened_d   = opened_q;
        if (req) begin
            // Back to the start, all slots closed
            state_d    = ST_HOLD;
            hold_cnt_d = '0;
            slot_d     = '0;
            gap_cnt_d  = '0;
            opened_d   = '0;
        end else begin
            case (state_q)
                ST_HOLD: begin
                    // Domain 0 opens on the edge that ends the hold time
                    if (hold_cnt_q == HOLD_LAST) begin
                        opened_d[0] = 1'b1;
                        slot_d      = SLOT_W'(1);
                        gap_cnt_d   = '0;
                        state_d     = (NDOM > 1) ? ST_RELEASE : ST_IDLE;
                    end else begin
                        hold_cnt_d = hold_cnt_q + 1'b1;
                    end
                end
                ST_RELEASE: begin
                    // Next slot opens gap+1 edges after the previous one
                    // >= keeps the walk going if gap shrinks mid-count
                    if (gap_cnt_q >= cfg.gap) begin
                        opened_d[slot_q] = 1'b1;
                        gap_cnt_d        = '0;
                        if (slot_q == SLOT_LAST) begin
                            state_d = ST_IDLE;
                        end else begin
                            slot_d = slot_q + 1'b1;
                        end
                    end else begin
                        gap_cnt_d = gap_cnt_q + 1'b1;
                    end
                end
                default: begin
                    // Idle, wait for the next request
                end
            endcase
        end
    end

    // --------------------
    // State and outputs
    // --------------------
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            state_q      <= ST_HOLD;
            hold_cnt_q   <= '0;
            slot_q       <= '0;
            gap_cnt_q    <= '0;
            opened_q     <= '0;
            domain_rst_n <= '0;
        end else begin
            state_q    <= state_d;
            hold_cnt_q <= hold_cnt_d;
            slot_q     <= slot_d;
            gap_cnt_q  <= gap_cnt_d;
            opened_q   <= opened_d;
            // Held domains stay low even after their slot has passed
            domain_rst_n <= opened_d & ~cfg.hold;
        end
    end

endmodule

`default_nettype wire

/* design/reset_ctrl_regs.sv */
//--------------------
// Strobe register port, writes act at the edge, reads return one cycle later
// CFG and CAUSE are cleared only by power-on
//--------------------
`default_nettype none

`include "rst_consts.svh"

module reset_ctrl_regs (
    input  logic                        clk,
    input  logic                        async_rst_n,
    input  logic                        ext_rst_n,
    input  logic                        wdt_bite,
    input  rst_pkg::reg_req_t           reg_req,
    input  logic [`RST_NUM_DOMAINS-1:0] domain_rst_n,
    input  logic                        seq_busy,
    output rst_pkg::rst_cfg_t           cfg,
    output logic                        sw_rst,
    output logic [`RST_DATA_W-1:0]      rd_data,
    output logic                        rd_valid
);

    logic wr_ctrl;
    logic wr_cfg;
    logic wr_cause;

    rst_pkg::rst_cause_t cause_q;
    rst_pkg::rst_cause_t cause_set;
    rst_pkg::rst_cause_t cause_clr;

    // Set once ext_rst_n has been seen high after power-on
    logic ext_armed_q;

    logic [`RST_DATA_W-1:0] rd_mux;

    // --------------------
    // Write decode
    // --------------------
    assign wr_ctrl  = reg_req.we && (reg_req.addr == `RST_ADDR_CTRL);
    assign wr_cfg   = reg_req.we && (reg_req.addr == `RST_ADDR_CFG);
    assign wr_cause = reg_req.we && (reg_req.addr == `RST_ADDR_CAUSE);

    // Software reset strobe, same cycle as the CTRL write
    assign sw_rst = wr_ctrl & reg_req.wdata[0];

    // Gap in bits 7..0, hold in bits 10..8
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            cfg.gap  <= `RST_GAP_W'(`RST_GAP_DEFAULT);
            cfg.hold <= '0;
        end else if (wr_cfg) begin
            cfg.gap  <= reg_req.wdata[7:0];
            cfg.hold <= reg_req.wdata[8 +: `RST_NUM_DOMAINS];
        end
    end

    // --------------------
    // Reset cause
    // --------------------

    // The ext synchronizer releases after this block on power-on
    // so its tail must not be logged as an external reset
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            ext_armed_q <= 1'b0;
        end else if (ext_rst_n) begin
            ext_armed_q <= 1'b1;
        end
    end

    always_comb begin
        cause_set.por = 1'b0;
        cause_set.ext = ~ext_rst_n & ext_armed_q;
        cause_set.sw  = sw_rst;
        cause_set.wdt = wdt_bite;
    end

    // Write one to clear
    assign cause_clr = wr_cause ? reg_req.wdata[3:0] : 4'b0000;

    // Our own reset is the power-on event, so por comes up set
    // Set beats clear in the same cycle
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            cause_q <= 4'b0001;
        end else begin
            cause_q <= (cause_q & ~cause_clr) | cause_set;
        end
    end

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        rd_mux = '0;
        case (reg_req.addr)
            `RST_ADDR_CFG: begin
                rd_mux[7:0]                  = cfg.gap;
                rd_mux[8 +: `RST_NUM_DOMAINS] = cfg.hold;
            end
            `RST_ADDR_CAUSE: begin
                rd_mux[3:0] = cause_q;
            end
            `RST_ADDR_STATUS: begin
                rd_mux[`RST_NUM_DOMAINS-1:0] = domain_rst_n;
                rd_mux[`RST_NUM_DOMAINS]     = seq_busy;
            end
            default: begin
                // CTRL reads as zero
                rd_mux = '0;
            end
        endcase
    end

    // Valid for exactly the cycle after re
    always_ff @(posedge clk or negedge async_rst_n) begin
        if (!async_rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= reg_req.re;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_req.re) begin
            rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* design/reset_manager.sv */
//--------------------
// Reset manager top, single clock. ext_rst_n has no glitch filter
//--------------------
`default_nettype none

`include "rst_consts.svh"

module reset_manager (
    input  logic                        clk,
    input  logic                        async_rst_n,
    input  logic                        ext_rst_n,
    input  logic                        wdt_bite,
    input  rst_pkg::reg_req_t           reg_req,
    output logic [`RST_DATA_W-1:0]      rd_data,
    output logic                        rd_valid,
    output logic [`RST_NUM_DOMAINS-1:0] domain_rst_n
);

    logic              por_sync_n;
    logic              ext_sync_n;
    logic              ext_in_n;
    logic              sw_rst;
    logic              seq_busy;
    rst_pkg::rst_cfg_t cfg;

    // Power-on also drives the external synchronizer into reset
    assign ext_in_n = ext_rst_n & async_rst_n;

    // --------------------
    // Input synchronizers
    // --------------------
    reset_stretch_sync #(
        .STRETCH_COUNT (`RST_POR_STRETCH)
    ) por_sync (
        .clk         (clk),
        .async_rst_n (async_rst_n),
        .sync_rst_n  (por_sync_n)
    );

    reset_stretch_sync #(
        .STRETCH_COUNT (`RST_EXT_STRETCH)
    ) ext_sync (
        .clk         (clk),
        .async_rst_n (ext_in_n),
        .sync_rst_n  (ext_sync_n)
    );

    // --------------------
    // Sequencer and registers
    // --------------------
    reset_sequencer u_sequencer (
        .clk          (clk),
        .async_rst_n  (por_sync_n),
        .ext_rst_n    (ext_sync_n),
        .sw_rst       (sw_rst),
        .wdt_bite     (wdt_bite),
        .cfg          (cfg),
        .domain_rst_n (domain_rst_n),
        .seq_busy     (seq_busy)
    );

    reset_ctrl_regs u_regs (
        .clk          (clk),
        .async_rst_n  (por_sync_n),
        .ext_rst_n    (ext_sync_n),
        .wdt_bite     (wdt_bite),
        .reg_req      (reg_req),
        .domain_rst_n (domain_rst_n),
        .seq_busy     (seq_busy),
        .cfg          (cfg),
        .sw_rst       (sw_rst),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid)
    );

endmodule

`default_nettype wire

/* tb/rst_clk_gen.sv */
//--------------------
// Free running testbench clock, starts low, no reset of its own
//--------------------
`default_nettype none

module rst_clk_gen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    // First rising edge after half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb/tb_reset_manager.sv */
//--------------------
// Directed tests of the reset manager with random gaps below 16 cycles
// Inputs change on the falling edge and outputs are sampled there too
//--------------------
`default_nettype none

`include "rst_consts.svh"

module tb_reset_manager;

    localparam int NDOM     = `RST_NUM_DOMAINS;
    localparam int WAIT_MAX = 400;
    localparam int RD_MAX   = 8;

    logic                   clk;
    logic                   async_rst_n;
    logic                   ext_rst_n;
    logic                   wdt_bite;
    rst_pkg::reg_req_t      reg_req;
    logic [`RST_DATA_W-1:0] rd_data;
    logic                   rd_valid;
    logic [NDOM-1:0]        domain_rst_n;

    integer errors;
    integer seed;
    // Gap currently held in CFG
    int     cur_gap;

    rst_clk_gen #(
        .PERIOD (40)
    ) clk_src (
        .clk (clk)
    );

    reset_manager uut (
        .clk          (clk),
        .async_rst_n  (async_rst_n),
        .ext_rst_n    (ext_rst_n),
        .wdt_bite     (wdt_bite),
        .reg_req      (reg_req),
        .rd_data      (rd_data),
        .rd_valid     (rd_valid),
        .domain_rst_n (domain_rst_n)
    );

    // --------------------
    // Bus and stimulus tasks
    // --------------------
    task automatic log_mismatch(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
        errors = errors + 1;
        $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, exp_val, act_val);
    endtask

    // One cycle strobe that takes effect on the rising edge in between
    task automatic reg_write(input logic [1:0] addr, input logic [15:0] data);
        @(negedge clk);
        reg_req.we    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        @(negedge clk);
        reg_req = '0;
    endtask

    task automatic reg_read(input logic [1:0] addr, output logic [15:0] data);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge clk);
        reg_req.re   = 1'b1;
        reg_req.addr = addr;
        @(negedge clk);
        reg_req = '0;
        while (!rd_valid && (waited < RD_MAX)) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (rd_valid) begin
            data = rd_data;
            // Valid lasts a single cycle
            @(negedge clk);
            if (rd_valid) begin
                errors = errors + 1;
                $display("rd_valid stayed high after a read of address %0d", addr);
            end
        end else begin
            errors = errors + 1;
            $display("timeout, no rd_valid after a read of address %0d", addr);
        end
    endtask

    task automatic wdt_pulse;
        @(negedge clk);
        wdt_bite = 1'b1;
        @(negedge clk);
        wdt_bite = 1'b0;
    endtask

    // Records the cycle of each domain's rise counted from the call
    // check_hold expects the first release RST_SOFT_HOLD cycles after a strobe
    task automatic wait_release(input logic [NDOM-1:0] exp_mask, input int gap,
                                input bit check_hold);
        int              cyc;
        int              prev;
        int              rise_cyc [NDOM];
        logic [NDOM-1:0] risen;
        cyc   = 0;
        prev  = -1;
        risen = '0;
        for (int d = 0; d < NDOM; d++) begin
            rise_cyc[d] = 0;
        end
        while (((risen & exp_mask) != exp_mask) && (cyc < WAIT_MAX)) begin
            @(negedge clk);
            cyc = cyc + 1;
            for (int d = 0; d < NDOM; d++) begin
                if (domain_rst_n[d] && !risen[d]) begin
                    risen[d]    = 1'b1;
                    rise_cyc[d] = cyc;
                end
            end
        end
        if ((risen & exp_mask) != exp_mask) begin
            errors = errors + 1;
            $display("timeout, domains %b did not all leave reset", exp_mask);
        end
        if ((risen & ~exp_mask) != '0) begin
            errors = errors + 1;
            $display("a held domain left reset, domains %b", risen & ~exp_mask);
        end
        // Skipped slots still count toward the spacing
        for (int d = 0; d < NDOM; d++) begin
            if (exp_mask[d]) begin
                if (prev < 0) begin
                    if (check_hold && (rise_cyc[d] != `RST_SOFT_HOLD)) begin
                        log_mismatch($sformatf("domain_rst_n[%0d] release cycle", d),
                                     `RST_SOFT_HOLD, rise_cyc[d]);
                    end
                end else if ((rise_cyc[d] - rise_cyc[prev]) != (d - prev) * (gap + 1)) begin
                    log_mismatch($sformatf("domain_rst_n[%0d] spacing", d),
                                 (d - prev) * (gap + 1), rise_cyc[d] - rise_cyc[prev]);
                end
                prev = d;
            end
        end
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic power_on_release;
        logic [15:0] data;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            if (domain_rst_n !== '0) begin
                log_mismatch("domain_rst_n in reset", 0, domain_rst_n);
            end
            if (rd_valid !== 1'b0) begin
                log_mismatch("rd_valid in reset", 0, rd_valid);
            end
        end
        async_rst_n = 1'b1;
        wait_release(3'b111, `RST_GAP_DEFAULT, 1'b0);
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h0001) begin
            log_mismatch("rd_data CAUSE", 16'h0001, data);
        end
        reg_write(`RST_ADDR_CAUSE, 16'h0001);
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h0000) begin
            log_mismatch("rd_data CAUSE", 16'h0000, data);
        end
    endtask

    task automatic cfg_round_trip;
        logic [15:0] data;
        integer      rnd;
        rnd     = $random(seed);
        cur_gap = rnd[3:0];
        // Keep the gap apart from the power-on value so a lost write shows
        if (cur_gap == `RST_GAP_DEFAULT) begin
            cur_gap = cur_gap + 1;
        end
        reg_write(`RST_ADDR_CFG, 16'(cur_gap));
        reg_read(`RST_ADDR_CFG, data);
        if (data !== 16'(cur_gap)) begin
            log_mismatch("rd_data CFG", cur_gap, data);
        end
        wdt_pulse();
        if (domain_rst_n !== '0) begin
            log_mismatch("domain_rst_n after bite", 0, domain_rst_n);
        end
        wait_release(3'b111, cur_gap, 1'b1);
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h0008) begin
            log_mismatch("rd_data CAUSE", 16'h0008, data);
        end
    endtask

    task automatic soft_reset_restart;
        logic [15:0] data;
        reg_write(`RST_ADDR_CTRL, 16'h0001);
        if (domain_rst_n !== '0) begin
            log_mismatch("domain_rst_n after CTRL write", 0, domain_rst_n);
        end
        wait_release(3'b111, cur_gap, 1'b1);
        reg_read(`RST_ADDR_CFG, data);
        if (data !== 16'(cur_gap)) begin
            log_mismatch("rd_data CFG", cur_gap, data);
        end
        // wdt from the previous test is still sticky
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h000c) begin
            log_mismatch("rd_data CAUSE", 16'h000c, data);
        end
    endtask

    task automatic hold_mask_release;
        logic [15:0] data;
        integer      rnd;
        int          waited;
        rnd     = $random(seed);
        cur_gap = rnd[3:0];
        waited  = 0;
        // The later ext test needs CFG to differ from its power-on value
        if (cur_gap == `RST_GAP_DEFAULT) begin
            cur_gap = cur_gap + 1;
        end
        reg_write(`RST_ADDR_CAUSE, 16'h000f);
        // Hold bit 1 sits at CFG bit 9
        reg_write(`RST_ADDR_CFG, 16'h0200 | 16'(cur_gap));
        wdt_pulse();
        if (domain_rst_n !== '0) begin
            log_mismatch("domain_rst_n after bite", 0, domain_rst_n);
        end
        wait_release(3'b101, cur_gap, 1'b1);
        repeat (4) begin
            @(negedge clk);
            if (domain_rst_n[1] !== 1'b0) begin
                log_mismatch("domain_rst_n[1] while held", 0, domain_rst_n[1]);
            end
        end
        // Clearing the hold bit in idle releases domain 1 right away
        reg_write(`RST_ADDR_CFG, 16'(cur_gap));
        while (!domain_rst_n[1] && (waited < 4)) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!domain_rst_n[1]) begin
            errors = errors + 1;
            $display("timeout, domain 1 stayed in reset after its hold bit was cleared");
        end
        reg_read(`RST_ADDR_STATUS, data);
        if (data !== 16'h0007) begin
            log_mismatch("rd_data STATUS", 16'h0007, data);
        end
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h0008) begin
            log_mismatch("rd_data CAUSE", 16'h0008, data);
        end
    endtask

    task automatic ext_pulse_restart;
        logic [15:0] data;
        reg_write(`RST_ADDR_CAUSE, 16'h000f);
        @(negedge clk);
        ext_rst_n = 1'b0;
        repeat (3) @(negedge clk);
        if (domain_rst_n !== '0) begin
            log_mismatch("domain_rst_n during ext pulse", 0, domain_rst_n);
        end
        ext_rst_n = 1'b1;
        // Stretch plus hold time keeps the sequence busy well past this read
        reg_read(`RST_ADDR_STATUS, data);
        if (data !== 16'h0008) begin
            log_mismatch("rd_data STATUS", 16'h0008, data);
        end
        wait_release(3'b111, cur_gap, 1'b0);
        reg_read(`RST_ADDR_STATUS, data);
        if (data !== 16'h0007) begin
            log_mismatch("rd_data STATUS", 16'h0007, data);
        end
        reg_read(`RST_ADDR_CFG, data);
        if (data !== 16'(cur_gap)) begin
            log_mismatch("rd_data CFG", cur_gap, data);
        end
        reg_read(`RST_ADDR_CAUSE, data);
        if (data !== 16'h0002) begin
            log_mismatch("rd_data CAUSE", 16'h0002, data);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        errors      = 0;
        seed        = 32'ha7ca3f7f;
        cur_gap     = `RST_GAP_DEFAULT;
        async_rst_n = 1'b0;
        ext_rst_n   = 1'b1;
        wdt_bite    = 1'b0;
        reg_req     = '0;
        power_on_release();
        cfg_round_trip();
        soft_reset_restart();
        hold_mask_release();
        ext_pulse_restart();
        $display("all tests done, errors: %0d", errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+design
design/rst_pkg.sv
design/reset_stretch_sync.sv
design/reset_sequencer.sv
design/reset_ctrl_regs.sv
design/reset_manager.sv
tb/rst_clk_gen.sv
tb/tb_reset_manager.sv
